//--- hdl/rv32_config.svh
/*
  Core width and register count for the RV32I execute stage.
  The halt word is reserved and never decodes as a real instruction.
*/
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// Data and address width
`define RV32_XLEN 32

// Architectural register count, x0 included
`define RV32_NREGS 32

// All-ones word stops the core
`define RV32_HALT_INSN 32'hFFFFFFFF

`endif

//--- hdl/rv32_pkg.sv
/*
  Shared types for the RV32I execute stage.
  branch_t and load_t values equal funct3, so they can be cast straight from it.
*/
`include "rv32_config.svh"

package rv32_pkg;

  typedef logic [`RV32_XLEN-1:0] word_t;

  // Major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Also used as store width, funct3 sits in the same place
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef struct packed {
    logic  valid;
    logic  prediction;
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_ex_t;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    alu_op_t    alu_op;
    logic       alu_a_sel;   // 0 rs1, 1 pc
    logic [1:0] alu_b_sel;   // 0 rs2, 1 imm_I, 2 imm_S, 3 imm_U
    logic [1:0] w_sel;       // 0 load data, 1 pc4, 2 imm_U, 3 ALU result
    logic       wen;
    logic       dren;
    logic       dwen;
    logic       branch;
    logic       jump;
    logic       j_sel;       // 1 JAL, 0 JALR
    load_t      load_type;
    logic       illegal;
    logic       halt;
    word_t      imm_I;
    word_t      imm_S;
    word_t      imm_SB;
    word_t      imm_UJ;
    word_t      imm_U;
  } ctrl_t;

  typedef struct packed {
    logic       ren;
    logic       wen;
    logic [3:0] byte_en;
    word_t      addr;
    word_t      wdata;
  } dram_req_t;

  typedef struct packed {
    logic  redirect;
    word_t brj_addr;
    logic  mal_l;
    logic  mal_s;
    logic  illegal;
    logic  halt;
  } ex_status_t;

endpackage

//--- hdl/control_unit.sv
/*
  Purely combinational RV32I decoder, no CSR, fence or system opcodes.
  Illegal words leave every side effect off, the halt word is not illegal.
*/
`timescale 1ns/1ns
`include "rv32_config.svh"

module control_unit import rv32_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sh_legal;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Right shifts may carry the arithmetic bit, other shifts must not
  assign sh_legal = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b101);

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    ctrl.rs1       = instr[19:15];
    ctrl.rs2       = instr[24:20];
    ctrl.rd        = instr[11:7];
    ctrl.alu_op    = ADD;
    ctrl.load_type = load_t'(funct3);
    // Immediates, all sign-extended from bit 31
    ctrl.imm_I  = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_S  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_SB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_UJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_U  = {instr[31:12], 12'b0};
    ctrl.halt   = (instr == `RV32_HALT_INSN);

    case (opcode_t'(instr[6:0]))
      OP: begin
        ctrl.alu_op  = f3_to_op(funct3, funct7[5]);
        ctrl.wen     = 1'b1;
        ctrl.w_sel   = 2'd3;
        ctrl.illegal = !((funct7 == 7'h00) ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OP_IMM: begin
        // Bit 30 only means SRAI, ADDI keeps its full immediate
        ctrl.alu_op    = f3_to_op(funct3, funct3 == 3'b101 && funct7[5]);
        ctrl.alu_b_sel = 2'd1;
        ctrl.wen       = 1'b1;
        ctrl.w_sel     = 2'd3;
        ctrl.illegal   = (funct3 == 3'b001 || funct3 == 3'b101) && !sh_legal;
      end
      LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 2'd2;
      end
      AUIPC: begin
        ctrl.alu_a_sel = 1'b1;
        ctrl.alu_b_sel = 2'd3;
        ctrl.wen       = 1'b1;
        ctrl.w_sel     = 2'd3;
      end
      JAL: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = 2'd1;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
      end
      JALR: begin
        ctrl.wen     = 1'b1;
        ctrl.w_sel   = 2'd1;
        ctrl.jump    = 1'b1;
        ctrl.illegal = (funct3 != 3'b000);
      end
      BRANCH: begin
        ctrl.branch  = 1'b1;
        ctrl.illegal = (funct3 == 3'b010 || funct3 == 3'b011);
      end
      LOAD: begin
        ctrl.alu_b_sel = 2'd1;
        ctrl.dren      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.illegal   = (funct3 == 3'b011 || funct3[2:1] == 2'b11);
      end
      STORE: begin
        ctrl.alu_b_sel = 2'd2;
        ctrl.dwen      = 1'b1;
        ctrl.illegal   = (funct3 > 3'b010);
      end
      default: ctrl.illegal = !ctrl.halt;
    endcase

    // Nothing from an illegal word may reach state
    if (ctrl.illegal) begin
      ctrl.wen    = 1'b0;
      ctrl.dren   = 1'b0;
      ctrl.dwen   = 1'b0;
      ctrl.branch = 1'b0;
      ctrl.jump   = 1'b0;
    end
  end

endmodule

//--- hdl/reg_file.sv
/*
  x0 reads zero and ignores writes. Reads are combinational, so a write
  shows up on the read ports in the cycle after its clock edge.
*/
`timescale 1ns/1ns
`include "rv32_config.svh"

module reg_file import rv32_pkg::*; (
  input  logic       CLK,
  input  logic       reset,
  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  input  logic [4:0] rd,
  input  logic       wen,
  input  word_t      w_data,
  output word_t      rs1_data,
  output word_t      rs2_data
);

  // x1 and up only
  word_t regs [1:`RV32_NREGS-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 1; i < `RV32_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/alu.sv
/*
  RV32I integer ALU, one combinational level.
  Shift amounts come from the low five bits of port_b.
*/
`timescale 1ns/1ns

module alu import rv32_pkg::*; (
  input  alu_op_t aluop,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      ADD:     port_out = port_a + port_b;
      SUB:     port_out = port_a - port_b;
      SLL:     port_out = port_a << shamt;
      // Set-less-than gives 0 or 1 in bit 0
      SLT:     port_out = word_t'($signed(port_a) < $signed(port_b));
      SLTU:    port_out = word_t'(port_a < port_b);
      XOR:     port_out = port_a ^ port_b;
      SRL:     port_out = port_a >> shamt;
      SRA:     port_out = word_t'($signed(port_a) >>> shamt);
      OR:      port_out = port_a | port_b;
      AND:     port_out = port_a & port_b;
      default: port_out = '0;
    endcase
  end

endmodule

//--- hdl/branch_res.sv
/*
  Branch condition and target. The target is always formed, the caller
  decides whether a branch is in flight at all.
*/
`timescale 1ns/1ns

module branch_res import rv32_pkg::*; (
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   pc,
  input  word_t   imm_sb,
  input  branch_t branch_type,
  output logic    branch_taken,
  output word_t   branch_addr
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (branch_type)
      BEQ:     branch_taken = eq;
      BNE:     branch_taken = !eq;
      BLT:     branch_taken = lt_s;
      BGE:     branch_taken = !lt_s;
      BLTU:    branch_taken = lt_u;
      BGEU:    branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  // imm_sb already carries the zero low bit
  assign branch_addr = pc + imm_sb;

endmodule

//--- hdl/dmem_align.sv
/*
  Little-endian byte lane handling for the data RAM.
  The same width code drives loads and stores, stores only use LB, LH and LW.
*/
`timescale 1ns/1ns

module dmem_align import rv32_pkg::*; (
  input  load_t      load_type,
  input  word_t      addr,
  input  word_t      store_data,
  input  word_t      rdata,
  output logic [3:0] byte_en,
  output word_t      wdata,
  output logic       mal,
  output word_t      load_ext
);

  logic [1:0]  off;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign off = addr[1:0];

  // Byte lanes and alignment
  always_comb begin
    byte_en = 4'b0000;
    mal     = 1'b0;
    case (load_type)
      LB, LBU: byte_en = 4'b0001 << off;
      LH, LHU: begin
        byte_en = off[1] ? 4'b1100 : 4'b0011;
        mal     = off[0];
      end
      LW: begin
        byte_en = 4'b1111;
        mal     = (off != 2'b00);
      end
      default: byte_en = 4'b0000;
    endcase
  end

  // Replicate narrow store data so every lane carries it
  always_comb begin
    case (load_type)
      LB:      wdata = {4{store_data[7:0]}};
      LH:      wdata = {2{store_data[15:0]}};
      default: wdata = store_data;
    endcase
  end

  // Pick the addressed lane out of the returned word
  assign rd_byte = rdata[8*off +: 8];
  assign rd_half = off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (load_type)
      LB:      load_ext = {{24{rd_byte[7]}}, rd_byte};
      LBU:     load_ext = {24'b0, rd_byte};
      LH:      load_ext = {{16{rd_half[15]}}, rd_half};
      LHU:     load_ext = {16'b0, rd_half};
      default: load_ext = rdata;
    endcase
  end

endmodule

//--- hdl/execute_stage.sv
/*
  Execute stage of the two-stage pipeline. Data RAM must answer in the same
  cycle, there is no stall path. Halt stays high until reset.
*/
`timescale 1ns/1ns

module execute_stage import rv32_pkg::*; (
  input  logic       CLK,
  input  logic       reset,
  input  fetch_ex_t  fetch_ex,
  input  word_t      dram_rdata,
  output dram_req_t  dram_req,
  output ex_status_t status
);

  ctrl_t      ctrl;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      w_data;
  logic       rf_wen;
  word_t      port_a;
  word_t      port_b;
  word_t      alu_out;
  logic       br_taken;
  word_t      br_addr;
  word_t      jump_addr;
  logic [3:0] byte_en;
  word_t      st_wdata;
  word_t      load_ext;
  logic       mal;
  logic       mem_ok;
  logic       halt_q;

  control_unit u_cu (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  reg_file u_rf (
    .CLK      (CLK),
    .reset    (reset),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wen      (rf_wen),
    .w_data   (w_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ALU operands
  assign port_a = ctrl.alu_a_sel ? fetch_ex.pc : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      2'd0:    port_b = rs2_data;
      2'd1:    port_b = ctrl.imm_I;
      2'd2:    port_b = ctrl.imm_S;
      default: port_b = ctrl.imm_U;
    endcase
  end

  alu u_alu (
    .aluop    (ctrl.alu_op),
    .port_a   (port_a),
    .port_b   (port_b),
    .port_out (alu_out)
  );

  // Branch type reuses funct3 from the load_type field
  branch_res u_br (
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (fetch_ex.pc),
    .imm_sb       (ctrl.imm_SB),
    .branch_type  (branch_t'(ctrl.load_type)),
    .branch_taken (br_taken),
    .branch_addr  (br_addr)
  );

  // JAL is pc relative, JALR drops bit 0 of its sum
  assign jump_addr = ctrl.j_sel ? fetch_ex.pc + ctrl.imm_UJ
                                : (rs1_data + ctrl.imm_I) & ~32'h1;

  dmem_align u_dm (
    .load_type  (ctrl.load_type),
    .addr       (alu_out),
    .store_data (rs2_data),
    .rdata      (dram_rdata),
    .byte_en    (byte_en),
    .wdata      (st_wdata),
    .mal        (mal),
    .load_ext   (load_ext)
  );

  // Write-back
  always_comb begin
    case (ctrl.w_sel)
      2'd0:    w_data = load_ext;
      2'd1:    w_data = fetch_ex.pc4;
      2'd2:    w_data = ctrl.imm_U;
      default: w_data = alu_out;
    endcase
  end

  // A misaligned load leaves rd untouched
  assign rf_wen = fetch_ex.valid && ctrl.wen && !(ctrl.dren && mal);

  // Memory strobes only for valid, aligned accesses
  assign mem_ok           = fetch_ex.valid && !mal;
  assign dram_req.ren     = mem_ok && ctrl.dren;
  assign dram_req.wen     = mem_ok && ctrl.dwen;
  assign dram_req.byte_en = (mem_ok && (ctrl.dren || ctrl.dwen)) ? byte_en : 4'b0000;
  assign dram_req.addr    = alu_out;
  assign dram_req.wdata   = st_wdata;

  // Redirect on any jump, or a branch that went against the prediction
  assign status.redirect = fetch_ex.valid &&
                           (ctrl.jump || (ctrl.branch && (br_taken != fetch_ex.prediction)));
  assign status.brj_addr = ctrl.jump ? jump_addr : (br_taken ? br_addr : fetch_ex.pc4);
  assign status.mal_l    = fetch_ex.valid && ctrl.dren && mal;
  assign status.mal_s    = fetch_ex.valid && ctrl.dwen && mal;
  assign status.illegal  = fetch_ex.valid && ctrl.illegal;
  assign status.halt     = halt_q;

  // Sticky halt
  always_ff @(posedge CLK) begin
    if (reset) begin
      halt_q <= 1'b0;
    end else if (fetch_ex.valid && ctrl.halt) begin
      halt_q <= 1'b1;
    end
  end

endmodule

//--- test/execute_stage_assert.sv
/*
  Protocol assertions bound into execute_stage, sampled on the rising clock.
  fail_count tallies every assertion failure for the closing summary.
*/
`timescale 1ns/1ns

module execute_stage_assert import rv32_pkg::*; (
  input logic       clk,
  input logic       reset,
  input fetch_ex_t  fetch_ex,
  input dram_req_t  dram_req,
  input ex_status_t status
);

  int unsigned fail_count = 0;

  // Data RAM never reads and writes in one cycle
  ren_wen_apart: assert property (@(posedge clk) disable iff (reset)
    !(dram_req.ren && dram_req.wen))
    else begin
      fail_count++;
      $error("data RAM read and write strobes high together");
    end

  // Idle slot drives no strobe, halt excepted
  idle_quiet: assert property (@(posedge clk) disable iff (reset)
    !fetch_ex.valid |-> !(dram_req.ren || dram_req.wen || (|dram_req.byte_en) ||
                          status.redirect || status.mal_l || status.mal_s || status.illegal))
    else begin
      fail_count++;
      $error("strobe high while fetch_ex.valid is low");
    end

  // Misaligned access is suppressed
  mal_blocks_access: assert property (@(posedge clk) disable iff (reset)
    (status.mal_l || status.mal_s) |-> (!dram_req.ren && !dram_req.wen))
    else begin
      fail_count++;
      $error("misaligned access still drives a data RAM strobe");
    end

endmodule

bind execute_stage execute_stage_assert u_assert (
  .clk      (CLK),
  .reset    (reset),
  .fetch_ex (fetch_ex),
  .dram_req (dram_req),
  .status   (status)
);

//--- test/execute_stage_checker.sv
/*
  Scoreboard for the execute stage, sampled on the falling clock edge.
  Shadow registers follow the RV32I rules. Load data comes from dram_rdata.
*/
`timescale 1ns/1ns
`include "rv32_config.svh"

module execute_stage_checker import rv32_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  fetch_ex_t  fetch_ex,
  input  dram_req_t  dram_req,
  input  word_t      dram_rdata,
  input  ex_status_t status,
  output int         error_count
);

  // Everything one instruction is expected to do
  typedef struct packed {
    dram_req_t  req;
    ex_status_t stat;
    logic       rf_wen;
    logic [4:0] rd;
    word_t      rf_data;
  } expect_t;

  word_t shadow [0:`RV32_NREGS-1];
  logic  halt_exp;
  int    errors = 0;

  assign error_count = errors;

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t x, input word_t y);
    word_t sra;
    sra = $signed(x) >>> y[4:0];
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'h0, $signed(x) < $signed(y)};
      3'd3:    return {31'h0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? sra : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      default: return x >= y;
    endcase
  endfunction

  // Size code 0 byte, 1 half, 2 word
  function automatic logic misaligned(input logic [1:0] size, input word_t ea);
    return (size == 2'd1 && ea[0]) || (size == 2'd2 && ea[1:0] != 2'b00);
  endfunction

  function automatic logic [3:0] lanes(input logic [1:0] size, input word_t ea);
    case (size)
      2'd0:    return 4'b0001 << ea[1:0];
      2'd1:    return 4'b0011 << ea[1:0];
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t extend(input logic [2:0] f3, input word_t ea, input word_t rdata);
    word_t s;
    // Addressed byte of the little-endian word moves down to bit 0
    s = rdata >> (8 * ea[1:0]);
    case (f3)
      3'd0:    return {{24{s[7]}}, s[7:0]};
      3'd1:    return {{16{s[15]}}, s[15:0]};
      3'd4:    return {24'h0, s[7:0]};
      3'd5:    return {16'h0, s[15:0]};
      default: return rdata;
    endcase
  endfunction

  function automatic word_t replicate(input logic [1:0] size, input word_t v);
    case (size)
      2'd0:    return {4{v[7:0]}};
      2'd1:    return {2{v[15:0]}};
      default: return v;
    endcase
  endfunction

  // Expected outputs and register write for one issued slot
  function automatic expect_t reference_result(input fetch_ex_t fe, input word_t a,
                                               input word_t b, input word_t rdata);
    expect_t    e;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      ea;
    logic       legal;
    logic       taken;
    logic       mis;
    f3    = fe.instr[14:12];
    f7    = fe.instr[31:25];
    imm_i = {{20{fe.instr[31]}}, fe.instr[31:20]};
    imm_s = {{20{fe.instr[31]}}, f7, fe.instr[11:7]};
    imm_b = {{20{fe.instr[31]}}, fe.instr[7], fe.instr[30:25], fe.instr[11:8], 1'b0};
    imm_j = {{12{fe.instr[31]}}, fe.instr[19:12], fe.instr[20], fe.instr[30:21], 1'b0};
    imm_u = {fe.instr[31:12], 12'h000};
    e     = '0;
    e.rd  = fe.instr[11:7];
    legal = 1'b1;
    case (fe.instr[6:0])
      7'b0110011: begin
        legal     = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        e.rf_wen  = 1'b1;
        e.rf_data = alu_ref(f3, f7[5], a, b);
      end
      7'b0010011: begin
        // Only the shift forms restrict the upper immediate bits
        legal     = !(f3 == 3'd1 && f7 != 7'h00) &&
                    !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        e.rf_wen  = 1'b1;
        e.rf_data = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
      end
      7'b0110111: begin
        e.rf_wen  = 1'b1;
        e.rf_data = imm_u;
      end
      7'b0010111: begin
        e.rf_wen  = 1'b1;
        e.rf_data = fe.pc + imm_u;
      end
      7'b1101111: begin
        e.rf_wen        = 1'b1;
        e.rf_data       = fe.pc4;
        e.stat.redirect = 1'b1;
        e.stat.brj_addr = fe.pc + imm_j;
      end
      7'b1100111: begin
        legal           = (f3 == 3'd0);
        e.rf_wen        = 1'b1;
        e.rf_data       = fe.pc4;
        e.stat.redirect = 1'b1;
        e.stat.brj_addr = (a + imm_i) & 32'hFFFF_FFFE;
      end
      7'b1100011: begin
        legal           = (f3 != 3'd2 && f3 != 3'd3);
        taken           = branch_ref(f3, a, b);
        e.stat.redirect = (taken != fe.prediction);
        e.stat.brj_addr = taken ? fe.pc + imm_b : fe.pc4;
      end
      7'b0000011: begin
        legal          = (f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7);
        ea             = a + imm_i;
        mis            = misaligned(f3[1:0], ea);
        e.req.addr     = ea;
        e.req.ren      = !mis;
        e.req.byte_en  = mis ? 4'h0 : lanes(f3[1:0], ea);
        e.stat.mal_l   = mis;
        e.rf_wen       = !mis;
        e.rf_data      = extend(f3, ea, rdata);
      end
      7'b0100011: begin
        legal          = (f3 <= 3'd2);
        ea             = a + imm_s;
        mis            = misaligned(f3[1:0], ea);
        e.req.addr     = ea;
        e.req.wen      = !mis;
        e.req.byte_en  = mis ? 4'h0 : lanes(f3[1:0], ea);
        e.req.wdata    = replicate(f3[1:0], b);
        e.stat.mal_s   = mis;
      end
      default: legal = (fe.instr == `RV32_HALT_INSN);
    endcase
    if (!legal) begin
      e              = '0;
      e.stat.illegal = 1'b1;
    end
    if (!fe.valid) begin
      e = '0;
    end
    return e;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected 0x%h actual 0x%h at %0t ns", name, exp, act, $time);
    end
  endtask

  always @(negedge clk) begin
    expect_t e;
    // Reset still unknown at time zero counts as held
    if (reset !== 1'b0) begin
      for (int i = 0; i < `RV32_NREGS; i++) begin
        shadow[i] = '0;
      end
      halt_exp = 1'b0;
    end else begin
      e = reference_result(fetch_ex, shadow[fetch_ex.instr[19:15]],
                           shadow[fetch_ex.instr[24:20]], dram_rdata);
      check_value("dram_req.ren", e.req.ren, dram_req.ren);
      check_value("dram_req.wen", e.req.wen, dram_req.wen);
      check_value("dram_req.byte_en", e.req.byte_en, dram_req.byte_en);
      if (e.req.ren || e.req.wen) begin
        check_value("dram_req.addr", e.req.addr, dram_req.addr);
      end
      if (e.req.wen) begin
        check_value("dram_req.wdata", e.req.wdata, dram_req.wdata);
      end
      check_value("status.redirect", e.stat.redirect, status.redirect);
      if (e.stat.redirect) begin
        check_value("status.brj_addr", e.stat.brj_addr, status.brj_addr);
      end
      check_value("status.mal_l", e.stat.mal_l, status.mal_l);
      check_value("status.mal_s", e.stat.mal_s, status.mal_s);
      check_value("status.illegal", e.stat.illegal, status.illegal);
      check_value("status.halt", halt_exp, status.halt);
      // Write lands on the coming edge in time for the next slot
      if (e.rf_wen && e.rd != 5'd0) begin
        shadow[e.rd] = e.rf_data;
      end
      if (fetch_ex.valid && fetch_ex.instr == `RV32_HALT_INSN) begin
        halt_exp = 1'b1;
      end
    end
  end

endmodule

//--- test/execute_stage_tb.sv
/*
  Random RV32I stream into the execute stage. Memory model holds 256 words,
  higher address bits wrap. x1 to x3 are load and store base registers only.
*/
`timescale 1ns/1ns
`include "rv32_config.svh"

module execute_stage_tb import rv32_pkg::*; ();

  logic       clk;
  logic       reset;
  fetch_ex_t  fetch_ex;
  word_t      dram_rdata;
  dram_req_t  dram_req;
  ex_status_t status;
  word_t      mem [0:255];
  word_t      pc;
  integer     seed;
  int         chk_errors;
  int         timeouts;
  int         n;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  execute_stage u_dut (
    .CLK        (clk),
    .reset      (reset),
    .fetch_ex   (fetch_ex),
    .dram_rdata (dram_rdata),
    .dram_req   (dram_req),
    .status     (status)
  );

  execute_stage_checker u_chk (
    .clk         (clk),
    .reset       (reset),
    .fetch_ex    (fetch_ex),
    .dram_req    (dram_req),
    .dram_rdata  (dram_rdata),
    .status      (status),
    .error_count (chk_errors)
  );

  // Same-cycle data memory, byte lanes written on the clock edge
  assign dram_rdata = mem[dram_req.addr[9:2]];

  always @(posedge clk) begin
    if (dram_req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (dram_req.byte_en[i]) begin
          mem[dram_req.addr[9:2]][8*i +: 8] <= dram_req.wdata[8*i +: 8];
        end
      end
    end
  end

  // I-type layout, R-type passes {funct7, rs2} as imm
  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // One slot on the rising edge, prediction bit at random
  task automatic issue(input word_t instr, input logic valid);
    logic [31:0] p;
    p = $random(seed);
    @(posedge clk);
    fetch_ex <= {valid, p[0], instr, pc, pc + 32'd4};
    pc = pc + 32'd4;
  endtask

  // Weighted mix over 32 slots
  task automatic random_instr(output word_t instr, output logic valid);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  base;
    logic [2:0]  f3;
    logic [11:0] off;
    logic [11:0] imm;
    r     = $random(seed);
    s     = $random(seed);
    // x0 now and then, never a base register
    rd    = (s[31:28] == 4'd0) ? 5'd0 : 5'd4 + 5'(s[27:20] % 28);
    base  = 5'd1 + 5'(s[19:16] % 3);
    // Mostly word aligned offsets, some with random low bits
    off   = (s[15:14] == 2'd0) ? {6'd0, s[5:0]} : {6'd0, s[5:2], 2'b00};
    valid = 1'b1;
    case (r[4:0]) inside
      [5'd0:5'd5]: begin
        f3    = r[7:5];
        imm   = {(r[8] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, r[13:9]};
        instr = enc_i(imm, r[18:14], f3, rd, 7'b0110011);
      end
      [5'd6:5'd10]: begin
        f3 = r[7:5];
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {(f3 == 3'd5 && r[8]) ? 7'h20 : 7'h00, r[13:9]};
        end else begin
          imm = r[19:8];
        end
        instr = enc_i(imm, r[24:20], f3, rd, 7'b0010011);
      end
      5'd11: instr = {r[31:12], rd, 7'b0110111};
      5'd12: instr = {r[31:12], rd, 7'b0010111};
      [5'd13:5'd16]: begin
        // 0..4 mapped onto LB LH LW LBU LHU
        f3 = 3'(r[7:5] % 5);
        if (f3 > 3'd2) begin
          f3 = f3 + 3'd1;
        end
        instr = enc_i(off, base, f3, rd, 7'b0000011);
      end
      [5'd17:5'd20]: begin
        f3    = 3'(r[7:5] % 3);
        instr = enc_s(off, r[12:8], base, f3);
      end
      [5'd21:5'd24]: begin
        // 0..5 mapped onto the six branch types
        f3 = 3'(r[7:5] % 6);
        if (f3 > 3'd1) begin
          f3 = f3 + 3'd2;
        end
        instr = enc_b({r[31:20], 1'b0}, (r[14:13] == 2'd0) ? r[12:8] : r[19:15], r[12:8], f3);
      end
      5'd25: instr = enc_j({r[31:12], 1'b0}, rd);
      5'd26: instr = enc_i(r[31:20], r[12:8], 3'd0, rd, 7'b1100111);
      5'd27: instr = enc_i({2'b00, s[7:0], 2'b00}, 5'd0, 3'd0, base, 7'b0010011);
      5'd28: instr = {r[31:7], 7'b0001011};
      5'd31: instr = enc_i({7'h01, r[13:9]}, r[18:14], r[7:5], rd, 7'b0110011);
      default: begin
        valid = 1'b0;
        instr = r;
      end
    endcase
  endtask

  initial begin
    word_t instr;
    logic  valid;
    seed     = 32'h98d7263a;
    timeouts = 0;
    pc       = 32'h0000_1000;
    reset    <= 1'b1;
    fetch_ex <= '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h6c, i[7:0] + 8'h91};
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (status.halt !== 1'b0 && n < 8);
    if (status.halt !== 1'b0) begin
      $display("Timeout: halt did not clear after reset");
      timeouts++;
    end

    // Every register reads zero after reset
    for (int i = 0; i < 32; i++) begin
      issue(enc_s(12'(4 * i), 5'(i), 5'd0, 3'd2), 1'b1);
    end
    // Base registers for loads and stores
    for (int i = 1; i < 4; i++) begin
      instr = $random(seed);
      issue(enc_i({2'b00, instr[7:0], 2'b00}, 5'd0, 3'd0, 5'(i), 7'b0010011), 1'b1);
    end
    for (int i = 0; i < 3000; i++) begin
      random_instr(instr, valid);
      issue(instr, valid);
    end

    issue(`RV32_HALT_INSN, 1'b1);
    n = 0;
    do begin
      random_instr(instr, valid);
      issue(instr, 1'b0);
      @(negedge clk);
      n++;
    end while (status.halt !== 1'b1 && n < 8);
    if (status.halt !== 1'b1) begin
      $display("Timeout: halt did not rise after the halt instruction");
      timeouts++;
    end
    // Halt level holds through more traffic
    for (int i = 0; i < 16; i++) begin
      random_instr(instr, valid);
      issue(instr, valid);
    end
    repeat (2) @(posedge clk);

    $display("Summary: %0d compare errors, %0d assertion failures, %0d timeouts",
             chk_errors, u_dut.u_assert.fail_count, timeouts);
    if (chk_errors == 0 && u_dut.u_assert.fail_count == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- execute_stage.f
+incdir+hdl
hdl/rv32_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_res.sv
hdl/dmem_align.sv
hdl/execute_stage.sv
test/execute_stage_assert.sv
test/execute_stage_checker.sv
test/execute_stage_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32_pkg.sv
      - hdl/control_unit.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/branch_res.sv
      - hdl/dmem_align.sv
      - hdl/execute_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/execute_stage_assert.sv
      - test/execute_stage_checker.sv
      - test/execute_stage_tb.sv
